/* src.f */
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/exec.sv
src/writeback.sv
src/eightbit.sv
dv/eightbit_checker.sv
dv/tb_eightbit.sv

/* dv/tb_eightbit.sv */
`timescale 1ns/1ps

module tb_eightbit;

    logic       clk;
    logic       rst_n;
    logic [7:0] data_in;
    logic [7:0] addr;
    logic [7:0] data_out;
    logic       we;

    logic [7:0] mem [0:255];
    logic [7:0] prog [0:63];
    logic [7:0] dat [0:31];   // image of 0xE0..0xFF
    int         plen   = 0;
    logic [7:0] exp_a [0:63];
    logic [7:0] exp_d [0:63];
    int         n_exp  = 0;
    int         cycles = 0;

    eightbit eightbit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .we       (we)
    );

    eightbit_checker chk_inst (
        .clk      (clk),
        .we       (we),
        .addr     (addr),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // same-cycle memory
    assign data_in = mem[addr];

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= data_out;
        end
    end

    function automatic logic [7:0] mem_op(input logic [1:0] op, input logic r,
                                          input logic [4:0] a5);
        return {op, r, a5};
    endfunction

    task automatic put(input logic [7:0] ins);
        prog[plen] = ins;
        plen++;
    endtask

    task automatic halt_here();
        put({2'b00, plen[5:0]});  // jump to itself
    endtask

    task automatic new_program();
        int i;
        plen = 0;
        for (i = 0; i < 32; i++) begin
            dat[i] = 8'h00;
        end
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i] = i[7:0] ^ 8'ha5;
        end
        for (i = 0; i < plen; i++) begin
            mem[i] = prog[i];
        end
        for (i = 0; i < 32; i++) begin
            mem[224 + i] = dat[i];
        end
    endtask

    // instruction level model, returns instructions up to and including the halt
    function automatic int ref_run();
        logic [7:0] rm [0:255];
        logic [7:0] pc;
        logic [7:0] ra;
        logic [7:0] rb;
        logic [7:0] ins;
        logic [7:0] da;
        logic [7:0] v;
        int         n;
        int         i;
        for (i = 0; i < 256; i++) begin
            rm[i] = mem[i];
        end
        pc    = 8'h00;
        ra    = 8'h00;
        rb    = 8'h00;
        n     = 0;
        n_exp = 0;
        while (n < 200) begin
            ins = rm[pc];
            n++;
            if (ins[7:6] == cpu_pkg::op_jmp) begin
                if (ins[5:0] == pc[5:0]) begin
                    break;
                end
                pc = {2'b00, ins[5:0]};
            end else begin
                da = {3'b111, ins[4:0]};
                v  = ins[5] ? ra : rb;
                case (ins[7:6])
                    cpu_pkg::op_ld: v = rm[da];
                    cpu_pkg::op_add: v = v + rm[da];
                    default: begin
                        rm[da]       = v;
                        exp_a[n_exp] = da;
                        exp_d[n_exp] = v;
                        n_exp++;
                    end
                endcase
                if (ins[7:6] != cpu_pkg::op_st) begin
                    if (ins[5]) ra = v;
                    else rb = v;
                end
                pc = pc + 8'd1;
            end
        end
        return n;
    endfunction

    task automatic run_test(input string name, input int reset_after);
        int         n_inst;
        int         limit;
        int         t0;
        int         i;
        bit         ok;
        logic [7:0] halt_pc;
        @(posedge clk);
        #1 rst_n = 1'b0;
        @(posedge clk);
        #1;
        load_image();
        n_inst  = ref_run();
        limit   = n_inst * 4 + 20;
        halt_pc = plen[7:0] - 8'd1;
        chk_inst.begin_test(name);
        for (i = 0; i < n_exp; i++) begin
            chk_inst.expect_store(exp_a[i], exp_d[i]);
        end
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        ok = 1'b1;
        if (reset_after > 0) begin
            t0 = cycles;
            while (chk_inst.idx < reset_after && cycles - t0 < limit) @(negedge clk);
            if (chk_inst.idx < reset_after) begin
                ok = 1'b0;
            end else begin
                @(posedge clk);
                #1 rst_n = 1'b0;
                @(posedge clk);
                #1 chk_inst.restart();  // core idle from here
                repeat (4) @(posedge clk);
                #1 rst_n = 1'b1;
            end
        end
        if (ok) begin
            t0 = cycles;
            while (addr !== halt_pc && cycles - t0 < limit) @(negedge clk);
            ok = (addr === halt_pc);
        end
        if (ok) begin
            repeat (6) @(negedge clk);  // room for a stray store
            chk_inst.end_test();
        end else begin
            chk_inst.timed_out(limit);
        end
    endtask

    initial begin
        int unsigned seed;
        int unsigned r32;
        logic [1:0]  op;
        int          k;
        int          i;
        int          n;
        rst_n = 1'b0;
        new_program();
        load_image();
        seed = 32'hc2b8;
        r32  = $urandom(seed);

        new_program();
        dat[0] = 8'h3c;
        dat[1] = 8'ha7;
        put(mem_op(cpu_pkg::op_ld, 1'b1, 5'd0));
        put(mem_op(cpu_pkg::op_ld, 1'b0, 5'd1));
        put(mem_op(cpu_pkg::op_st, 1'b0, 5'd8));
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd9));
        halt_here();
        run_test("load_store", 0);

        new_program();
        dat[0] = 8'hf0;
        dat[1] = 8'h20;
        put(mem_op(cpu_pkg::op_ld, 1'b1, 5'd0));
        put(mem_op(cpu_pkg::op_add, 1'b1, 5'd1));  // 0xf0 + 0x20 wraps
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd2));
        halt_here();
        run_test("add_wrap", 0);

        new_program();
        dat[0] = 8'h5d;
        put(mem_op(cpu_pkg::op_ld, 1'b1, 5'd0));
        put(8'h03);
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd4));  // skipped
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd5));
        halt_here();
        run_test("jump_skip", 0);

        new_program();
        dat[0] = 8'h11;
        dat[1] = 8'h22;
        put(mem_op(cpu_pkg::op_ld, 1'b1, 5'd0));
        put(mem_op(cpu_pkg::op_ld, 1'b0, 5'd1));
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd7));
        put(mem_op(cpu_pkg::op_st, 1'b0, 5'd7));
        halt_here();
        run_test("reg_select", 0);

        for (k = 0; k < 20; k++) begin
            new_program();
            for (i = 0; i < 32; i++) begin
                r32    = $urandom;
                dat[i] = r32[7:0];
            end
            n = 4 + $urandom % 9;
            for (i = 0; i < n; i++) begin
                op  = 1 + $urandom % 3;  // ld, st or add
                r32 = $urandom;
                put(mem_op(op, r32[5], r32[4:0]));
            end
            halt_here();
            run_test($sformatf("random_%0d", k), 0);
        end

        // operands only come from 0..2, stores land at 0x10.. so a rerun sees the same data
        new_program();
        dat[0] = 8'h81;
        dat[1] = 8'h9c;
        dat[2] = 8'h47;
        // a and b are added to before any load, stale values would show
        put(mem_op(cpu_pkg::op_add, 1'b1, 5'd0));
        put(mem_op(cpu_pkg::op_add, 1'b0, 5'd1));
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd16));
        put(mem_op(cpu_pkg::op_st, 1'b0, 5'd17));
        put(mem_op(cpu_pkg::op_add, 1'b1, 5'd1));
        put(mem_op(cpu_pkg::op_st, 1'b1, 5'd18));
        put(mem_op(cpu_pkg::op_add, 1'b0, 5'd2));
        put(mem_op(cpu_pkg::op_st, 1'b0, 5'd19));
        halt_here();
        run_test("mid_reset", 2);

        chk_inst.report();
        if (chk_inst.err_total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/eightbit_checker.sv */
`timescale 1ns/1ps

module eightbit_checker (
    input logic       clk,
    input logic       we,
    input logic [7:0] addr,
    input logic [7:0] data_out
);

    logic [7:0] exp_a [0:63];
    logic [7:0] exp_d [0:63];
    int         n_exp     = 0;
    int         idx       = 0;  // next expected store
    int         test_err  = 0;
    int         err_total = 0;
    int         n_pass    = 0;
    int         n_fail    = 0;
    bit         armed     = 1'b0;
    string      cur_name  = "";

    task automatic begin_test(input string name);
        cur_name = name;
        n_exp    = 0;
        idx      = 0;
        test_err = 0;
        armed    = 1'b1;
    endtask

    task automatic expect_store(input logic [7:0] a, input logic [7:0] d);
        exp_a[n_exp] = a;
        exp_d[n_exp] = d;
        n_exp++;
    endtask

    // core was reset, store sequence starts over
    task automatic restart();
        idx = 0;
    endtask

    task automatic end_test();
        if (idx < n_exp) begin
            $display("%s: missing stores, saw %0d of %0d", cur_name, idx, n_exp);
            test_err++;
        end
        if (test_err == 0) begin
            n_pass++;
            $display("%s passed, %0d stores", cur_name, idx);
        end else begin
            n_fail++;
            $display("%s failed, %0d errors", cur_name, test_err);
        end
        err_total += test_err;
        armed = 1'b0;
    endtask

    task automatic timed_out(input int limit);
        $display("%s: timeout, halt loop not reached within %0d cycles", cur_name, limit);
        test_err++;
        end_test();
    endtask

    task automatic report();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, err_total);
    endtask

    // bus is settled mid-cycle
    always @(negedge clk) begin
        if (we === 1'b1) begin
            if (!armed) begin
                $display("store of %h to %h while no test is running", data_out, addr);
                err_total++;
            end else if (addr[7:5] != 3'b111) begin
                $display("%s: store outside data space at %h", cur_name, addr);
                test_err++;
            end else if (idx >= n_exp) begin
                $display("%s: extra store of %h to %h", cur_name, data_out, addr);
                test_err++;
            end else begin
                if (addr !== exp_a[idx]) begin
                    $display("ERR addr store %0d: got %h expected %h", idx, addr, exp_a[idx]);
                    test_err++;
                end
                if (data_out !== exp_d[idx]) begin
                    $display("ERR data_out store %0d: got %h expected %h",
                             idx, data_out, exp_d[idx]);
                    test_err++;
                end
                idx++;
            end
        end else if (we !== 1'b0 && armed) begin
            $display("%s: write strobe is unknown", cur_name);
            test_err++;
        end
    end

endmodule

/* src/eightbit.sv */
`timescale 1ns/1ps

module eightbit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  data_in,
    output logic [7:0]  addr,
    output logic [7:0]  data_out,
    output logic        we
);

    logic [2:0]                 state;
    logic [2:0]                 state_nxt;
    logic [cpu_pkg::data_w-1:0] pc;
    logic [cpu_pkg::data_w-1:0] addr_q;

    logic                       fetch_start;
    logic                       fetch_done;
    logic [cpu_pkg::data_w-1:0] fetch_addr;
    cpu_pkg::inst_t             inst;

    logic                       decode_start;
    logic                       decode_done;
    logic [1:0]                 dec_op;
    logic [5:0]                 dec_target;
    logic [4:0]                 dec_data_addr;
    logic                       dec_srcdst;

    logic                       exec_start;
    logic                       exec_done;
    logic [cpu_pkg::data_w-1:0] exec_val;
    logic [cpu_pkg::data_w-1:0] exec_mem_addr;
    logic [cpu_pkg::data_w-1:0] exec_result;

    logic                       wb_start;
    logic                       wb_done;
    logic [cpu_pkg::data_w-1:0] a;
    logic [cpu_pkg::data_w-1:0] b;

    fetch fetch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (fetch_start),
        .pc         (pc),
        .data_in    (data_in),
        .fetch_addr (fetch_addr),
        .inst       (inst),
        .done       (fetch_done)
    );

    decode decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (decode_start),
        .inst       (inst),
        .op         (dec_op),
        .target     (dec_target),
        .data_addr  (dec_data_addr),
        .srcdst     (dec_srcdst),
        .done       (decode_done)
    );

    exec exec_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (exec_start),
        .op         (dec_op),
        .data_addr  (dec_data_addr),
        .val        (exec_val),
        .data_in    (data_in),
        .mem_addr   (exec_mem_addr),
        .mem_data   (data_out),
        .we         (we),
        .result     (exec_result),
        .done       (exec_done)
    );

    writeback writeback_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (wb_start),
        .srcdst     (dec_srcdst),
        .val        (exec_result),
        .a          (a),
        .b          (b),
        .done       (wb_done)
    );

    assign exec_val = dec_srcdst ? a : b;  // operand for store and add

    // strobes and next state
    always_comb begin
        state_nxt    = state;
        fetch_start  = 1'b0;
        decode_start = 1'b0;
        exec_start   = 1'b0;
        wb_start     = 1'b0;
        case (state)
            cpu_pkg::st_idle: begin
                state_nxt = cpu_pkg::st_fetch;
            end
            cpu_pkg::st_fetch: begin
                fetch_start = 1'b1;
            end
            cpu_pkg::st_decode: begin
                decode_start = fetch_done;
                if (fetch_done) begin
                    state_nxt = cpu_pkg::st_exec;
                end
            end
            cpu_pkg::st_exec: begin
                if (decode_done) begin
                    if (dec_op == cpu_pkg::op_jmp) begin
                        state_nxt = cpu_pkg::st_fetch; // pc reloads at this edge
                    end else begin
                        exec_start = 1'b1;
                        state_nxt  = cpu_pkg::st_wb;
                    end
                end
            end
            cpu_pkg::st_wb: begin
                if (exec_done) begin
                    if (dec_op == cpu_pkg::op_st) begin
                        fetch_start = 1'b1;  // store retires here
                    end else begin
                        wb_start  = 1'b1;
                        state_nxt = cpu_pkg::st_retire;
                    end
                end
            end
            cpu_pkg::st_retire: begin
                fetch_start = wb_done;
            end
            default: begin
                state_nxt = cpu_pkg::st_idle;
            end
        endcase
        if (fetch_start) begin
            state_nxt = cpu_pkg::st_decode;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cpu_pkg::st_idle;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            if (decode_done && state == cpu_pkg::st_exec) begin
                if (dec_op == cpu_pkg::op_jmp) begin
                    pc <= {2'b00, dec_target};
                end else begin
                    pc <= pc + 1'b1;  // ready before the next fetch
                end
            end
        end
    end

    // bus address, held between unit accesses
    always_comb begin
        if (fetch_start) begin
            addr = fetch_addr;
        end else if (exec_start) begin
            addr = exec_mem_addr;
        end else begin
            addr = addr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr;
        end
    end

endmodule

/* src/writeback.sv */
`timescale 1ns/1ps

module writeback (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        srcdst,
    input  logic [cpu_pkg::data_w-1:0]  val,
    output logic [cpu_pkg::data_w-1:0]  a,
    output logic [cpu_pkg::data_w-1:0]  b,
    output logic                        done
);

    // register file of two, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a <= '0;
            b <= '0;
        end else if (start) begin
            if (srcdst) begin
                a <= val;
            end else begin
                b <= val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

/* src/exec.sv */
`timescale 1ns/1ps

module exec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [1:0]                  op,
    input  logic [4:0]                  data_addr,
    input  logic [cpu_pkg::data_w-1:0]  val,
    input  logic [cpu_pkg::data_w-1:0]  data_in,
    output logic [cpu_pkg::data_w-1:0]  mem_addr,
    output logic [cpu_pkg::data_w-1:0]  mem_data,
    output logic                        we,
    output logic [cpu_pkg::data_w-1:0]  result,
    output logic                        done
);

    logic [cpu_pkg::data_w-1:0] sum;

    // data space is the top 32 bytes
    assign mem_addr = {cpu_pkg::data_base, data_addr};

    // store value goes straight out with the strobe
    assign mem_data = val;
    assign we       = start && (op == cpu_pkg::op_st);

    assign sum = val + data_in;  // wraps at 8 bits

    always_ff @(posedge clk) begin
        if (start) begin
            case (op)
                cpu_pkg::op_ld: begin
                    result <= data_in;
                end
                cpu_pkg::op_add: begin
                    result <= sum;
                end
                default: begin
                    result <= val;  // store echoes the written byte
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

/* src/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  cpu_pkg::inst_t  inst,
    output logic [1:0]      op,
    output logic [5:0]      target,
    output logic [4:0]      data_addr,
    output logic            srcdst,
    output logic            done
);

    logic is_jmp;

    // opcode sits in the same bits for both views
    assign is_jmp = (inst.jmp.op == cpu_pkg::op_jmp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op   <= cpu_pkg::op_jmp;
            done <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                op <= inst.jmp.op;
            end
        end
    end

    // fields kept until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            if (is_jmp) begin
                target <= inst.jmp.target;
            end else begin
                srcdst    <= inst.mem.srcdst;
                data_addr <= inst.mem.addr;
            end
        end
    end

endmodule

/* src/fetch.sv */
`timescale 1ns/1ps

module fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [cpu_pkg::data_w-1:0]  pc,
    input  logic [cpu_pkg::data_w-1:0]  data_in,
    output logic [cpu_pkg::data_w-1:0]  fetch_addr,
    output cpu_pkg::inst_t              inst,
    output logic                        done
);

    // the top only routes this onto the bus while start is high
    assign fetch_addr = pc;

    // memory answers in the same cycle, so the byte is there at the edge
    always_ff @(posedge clk) begin
        if (start) begin
            inst <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;  // one cycle latency
        end
    end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

    // datapath and bus width
    localparam int data_w = 8;

    // opcodes, instruction bits 7:6
    localparam logic [1:0] op_jmp = 2'b00;
    localparam logic [1:0] op_ld  = 2'b01;
    localparam logic [1:0] op_st  = 2'b10;
    localparam logic [1:0] op_add = 2'b11;

    // data space lives at 0xE0..0xFF
    localparam logic [2:0] data_base = 3'b111;

    // sequencer states
    localparam logic [2:0] st_idle   = 3'd0; // held in reset
    localparam logic [2:0] st_fetch  = 3'd1; // issue fetch from pc
    localparam logic [2:0] st_decode = 3'd2; // wait fetch, start decode
    localparam logic [2:0] st_exec   = 3'd3; // wait decode, jump or start exec
    localparam logic [2:0] st_wb     = 3'd4; // wait exec, start writeback
    localparam logic [2:0] st_retire = 3'd5; // wait writeback

    // one instruction byte, read as a jump or as a memory op
    typedef union packed {
        struct packed {
            logic [1:0] op;
            logic [5:0] target;  // program space 0x00..0x3F
        } jmp;
        struct packed {
            logic [1:0] op;
            logic       srcdst;  // 1 = a, 0 = b
            logic [4:0] addr;    // offset into data space
        } mem;
    } inst_t;

endpackage
